/* common/fc_pkg.sv */
// Data types and widths shared by the FC layer datapath
// Element, word and accumulator types plus the requantization constant

package fc_pkg;

  // Stream and buffer word
  localparam int DATA_W = 32;

  // Elements per word, which is also the length of the PE chain
  localparam int BYTES_PER_WORD = 4;

  // Accumulator width
  localparam int ACC_W = 28;

  // Width of the size input in elements
  localparam int SIZE_W = 11;

  // Right shift applied before saturation to 7 bits
  localparam int OUT_SHIFT = 6;

  // Signed feature, weight or bias element
  typedef logic signed [7:0] elem_t;

  // Byte i of a word holds element 4w+i
  typedef logic [DATA_W-1:0] word_t;

  typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* common/fc_ctrl_pkg.sv */
// Controller encodings for the FC layer
// Host command codes and layer FSM states

package fc_ctrl_pkg;

  // Command sampled with the start pulse
  typedef enum logic [1:0] {
    CMD_LOAD_FEAT = 2'd0,
    CMD_LOAD_BIAS = 2'd1,
    CMD_RUN       = 2'd2
  } fc_cmd_e;

  // Layer FSM
  typedef enum logic [3:0] {
    ST_IDLE        = 4'd0,
    ST_RECV_FEAT   = 4'd1,
    ST_RECV_BIAS   = 4'd2,
    ST_RECV_WEIGHT = 4'd3,
    ST_COMPUTE     = 4'd4,
    ST_DRAIN       = 4'd5,
    ST_SEND        = 4'd6
  } fc_state_e;

endpackage

/* pe/pe_mult.sv */
// Four-stage pipelined signed 8x8 multiplier
// Works on magnitudes and restores the sign in the last stage

`timescale 1ns/10ps

module pe_mult
  import fc_pkg::*;
(
  input  logic  clk,
  input  logic  en,
  input  elem_t a,
  input  elem_t b,
  output acc_t  p
);

  logic [7:0]  a_mag;
  logic [7:0]  b_mag;
  logic        sign1;
  logic        sign2;
  logic        sign3;
  logic [15:0] pp [8];
  logic [15:0] sum2 [4];
  logic [15:0] sum3;

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1 takes magnitudes and the product sign
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (en) begin
      a_mag <= a[7] ? 8'(-a) : 8'(a);
      b_mag <= b[7] ? 8'(-b) : 8'(b);
      sign1 <= a[7] ^ b[7];
    end
  end

  // Shifted partial products, one per multiplier bit
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      pp[i] = b_mag[i] ? (16'(a_mag) << i) : 16'd0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stages 2 and 3 reduce the partial products pairwise
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (en) begin
      for (int k = 0; k < 4; k++) begin
        sum2[k] <= pp[2*k] + pp[2*k+1];
      end
      sign2 <= sign1;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      sum3  <= (sum2[0] + sum2[1]) + (sum2[2] + sum2[3]);
      sign3 <= sign2;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 4 applies the sign
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (en) begin
      p <= sign3 ? -acc_t'(sum3) : acc_t'(sum3);
    end
  end

endmodule

/* pe/pe_mac.sv */
// Processing element of the systolic chain
// Multiplies feature by weight, accumulates, and forwards the feature

`timescale 1ns/10ps

module pe_mac
  import fc_pkg::*;
(
  input  logic  clk,
  input  logic  en,
  input  logic  first,
  input  elem_t a_in,
  input  elem_t b,
  output elem_t a_out,
  output acc_t  acc
);

  acc_t       p;
  logic [3:0] first_d;

  pe_mult u_mult (
    .clk (clk),
    .en  (en),
    .a   (a_in),
    .b   (b),
    .p   (p)
  );

  always_ff @(posedge clk) begin
    if (en) begin
      // First flag rides along with the multiplier pipeline
      first_d <= {first_d[2:0], first};
      // Next PE sees this feature one cycle later
      a_out   <= a_in;
      if (first_d[3]) begin
        acc <= p;
      end else begin
        acc <= acc + p;
      end
    end
  end

endmodule

/* design/fc_buffer.sv */
// Single-port word memory with a registered read
// Holds feature, bias or weight words

`timescale 1ns/10ps

module fc_buffer
  import fc_pkg::*;
#(
  parameter int DEPTH = 64
) (
  input  logic                     clk,
  input  logic                     en,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  word_t                    din,
  output word_t                    dout
);

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= din;
      end
      dout <= mem[addr];
    end
  end

endmodule

/* design/fc_ctrl.sv */
// Layer controller for the FC accelerator
// Runs the loads, feeds skewed operands to the PE chain and sends results

`timescale 1ns/10ps

module fc_ctrl
  import fc_pkg::*;
  import fc_ctrl_pkg::*;
#(
  parameter  int FEAT_DEPTH = 64,
  parameter  int BIAS_DEPTH = 16,
  localparam int FA_W       = $clog2(FEAT_DEPTH),
  localparam int BA_W       = $clog2(BIAS_DEPTH)
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  fc_cmd_e                   cmd,
  input  logic                      start,
  input  logic [SIZE_W-1:0]         size,
  input  logic                      s_axis_tvalid,
  output logic                      s_axis_tready,
  input  logic                      m_axis_tready,
  output logic                      m_axis_tvalid,
  output logic                      m_axis_tlast,
  output word_t                     m_axis_tdata,
  output logic                      feat_en,
  output logic                      feat_we,
  output logic [FA_W-1:0]           feat_addr,
  output logic                      bias_en,
  output logic                      bias_we,
  output logic [BA_W-1:0]           bias_addr,
  output logic [BYTES_PER_WORD-1:0] w_en,
  output logic [BYTES_PER_WORD-1:0] w_we,
  output logic [FA_W-1:0]           w_addr,
  input  word_t                     feat_dout,
  input  word_t                     bias_dout,
  input  word_t                     w_dout0,
  input  word_t                     w_dout1,
  input  word_t                     w_dout2,
  input  word_t                     w_dout3,
  output elem_t                     pe_a,
  output elem_t                     pe_b0,
  output elem_t                     pe_b1,
  output elem_t                     pe_b2,
  output elem_t                     pe_b3,
  output logic                      pe_en,
  output logic                      pe_first0,
  output logic                      pe_first1,
  output logic                      pe_first2,
  output logic                      pe_first3,
  output word_t                     requant_bias,
  input  word_t                     requant_result,
  output logic                      feat_loaded,
  output logic                      bias_loaded,
  output logic                      done
);

  fc_state_e          state;
  logic [SIZE_W-3:0]  feat_words;
  logic [SIZE_W-3:0]  bias_words;
  logic [SIZE_W-3:0]  cnt;
  logic [SIZE_W-3:0]  group;
  logic [1:0]         row;
  logic [1:0]         ph;
  logic               beat;
  logic               rd;
  logic               rd_d;
  logic               op_vld;
  logic [2:0]         byte_left;
  logic [2:0]         dcnt;
  logic [2:0]         first_sr;
  word_t              feat_sh;
  word_t              w_sh [BYTES_PER_WORD];
  elem_t              w_byte [BYTES_PER_WORD];
  elem_t              b1_d;
  elem_t              b2_d [2];
  elem_t              b3_d [3];

  ////////////////////////////////////////////////////////////////////////////
  // Buffer access
  ////////////////////////////////////////////////////////////////////////////

  assign s_axis_tready = (state == ST_RECV_FEAT) || (state == ST_RECV_BIAS) ||
                         (state == ST_RECV_WEIGHT);
  assign beat = s_axis_tvalid && s_axis_tready;

  // One word read per four compute cycles
  assign rd = (state == ST_COMPUTE) && (ph == 2'd0) && (cnt != feat_words);

  assign feat_we   = beat && (state == ST_RECV_FEAT);
  assign feat_en   = feat_we || rd;
  assign feat_addr = cnt[FA_W-1:0];

  assign bias_we   = beat && (state == ST_RECV_BIAS);
  assign bias_en   = bias_we || ((state == ST_DRAIN) && (dcnt == 3'd0));
  assign bias_addr = (state == ST_DRAIN) ? group[BA_W-1:0] : cnt[BA_W-1:0];

  assign w_addr = cnt[FA_W-1:0];

  always_comb begin
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      w_we[i] = beat && (state == ST_RECV_WEIGHT) && (row == 2'(i));
      w_en[i] = w_we[i] || rd;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand streams
  ////////////////////////////////////////////////////////////////////////////

  // Zero operands outside the valid window keep drain products at zero
  assign op_vld = (byte_left != 3'd0);

  always_comb begin
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      w_byte[i] = op_vld ? elem_t'(w_sh[i][7:0]) : '0;
    end
  end

  assign pe_a  = op_vld ? elem_t'(feat_sh[7:0]) : '0;
  assign pe_b0 = w_byte[0];
  assign pe_b1 = b1_d;
  assign pe_b2 = b2_d[1];
  assign pe_b3 = b3_d[2];

  // Byte 0 of word 0 starts a new sum
  assign pe_first0 = (state == ST_COMPUTE) && (byte_left == 3'd4) && (cnt == 1);
  assign pe_first1 = first_sr[0];
  assign pe_first2 = first_sr[1];
  assign pe_first3 = first_sr[2];

  assign pe_en = (state == ST_COMPUTE) || (state == ST_DRAIN);

  always_ff @(posedge clk) begin
    if (rd_d) begin
      feat_sh <= feat_dout;
      w_sh[0] <= w_dout0;
      w_sh[1] <= w_dout1;
      w_sh[2] <= w_dout2;
      w_sh[3] <= w_dout3;
    end else begin
      feat_sh <= feat_sh >> 8;
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
        w_sh[i] <= w_sh[i] >> 8;
      end
    end
    // Weight i lags by i cycles to meet the feature along the chain
    b1_d    <= w_byte[1];
    b2_d[0] <= w_byte[2];
    b2_d[1] <= b2_d[0];
    b3_d[0] <= w_byte[3];
    b3_d[1] <= b3_d[0];
    b3_d[2] <= b3_d[1];
    if ((state == ST_DRAIN) && (dcnt == 3'd1)) begin
      requant_bias <= bias_dout;
    end
    if ((state == ST_DRAIN) && (dcnt == 3'd7)) begin
      m_axis_tdata <= requant_result;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Layer FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state         <= ST_IDLE;
      feat_words    <= '0;
      bias_words    <= '0;
      cnt           <= '0;
      group         <= '0;
      row           <= '0;
      ph            <= '0;
      rd_d          <= 1'b0;
      byte_left     <= '0;
      dcnt          <= '0;
      first_sr      <= '0;
      m_axis_tvalid <= 1'b0;
      m_axis_tlast  <= 1'b0;
      feat_loaded   <= 1'b0;
      bias_loaded   <= 1'b0;
      done          <= 1'b0;
    end else begin
      done     <= 1'b0;
      rd_d     <= rd;
      first_sr <= {first_sr[1:0], pe_first0};
      if (rd_d) begin
        byte_left <= 3'd4;
      end else if (op_vld) begin
        byte_left <= byte_left - 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (start) begin
            cnt <= '0;
            case (cmd)
              CMD_LOAD_FEAT: begin
                feat_words  <= size[SIZE_W-1:2];
                feat_loaded <= 1'b0;
                state       <= ST_RECV_FEAT;
              end
              CMD_LOAD_BIAS: begin
                bias_words  <= size[SIZE_W-1:2];
                bias_loaded <= 1'b0;
                state       <= ST_RECV_BIAS;
              end
              CMD_RUN: begin
                if (feat_loaded && bias_loaded) begin
                  group <= '0;
                  row   <= '0;
                  state <= ST_RECV_WEIGHT;
                end
              end
              default: ;
            endcase
          end
        end
        ST_RECV_FEAT: begin
          if (beat) begin
            cnt <= cnt + 1'b1;
            if (cnt == feat_words - 1'b1) begin
              feat_loaded <= 1'b1;
              state       <= ST_IDLE;
            end
          end
        end
        ST_RECV_BIAS: begin
          if (beat) begin
            cnt <= cnt + 1'b1;
            if (cnt == bias_words - 1'b1) begin
              bias_loaded <= 1'b1;
              state       <= ST_IDLE;
            end
          end
        end
        ST_RECV_WEIGHT: begin
          if (beat) begin
            if (cnt == feat_words - 1'b1) begin
              // Row done, the fourth row of a group starts compute
              cnt <= '0;
              row <= row + 1'b1;
              if (row == 2'd3) begin
                ph    <= '0;
                state <= ST_COMPUTE;
              end
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        ST_COMPUTE: begin
          ph <= ph + 1'b1;
          if (rd) begin
            cnt <= cnt + 1'b1;
          end
          if ((cnt == feat_words) && !rd_d && (byte_left == 3'd1)) begin
            dcnt  <= '0;
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          // Last PE settles 8 cycles after its final operand leaves PE 0
          dcnt <= dcnt + 1'b1;
          if (dcnt == 3'd7) begin
            m_axis_tvalid <= 1'b1;
            m_axis_tlast  <= (group == bias_words - 1'b1);
            state         <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (m_axis_tready) begin
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
            if (m_axis_tlast) begin
              done  <= 1'b1;
              state <= ST_IDLE;
            end else begin
              group <= group + 1'b1;
              cnt   <= '0;
              state <= ST_RECV_WEIGHT;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* design/fc_requant.sv */
// Output requantizer for one group of four neurons
// Bias add, ReLU, shift and 7-bit saturation packed into one word

`timescale 1ns/10ps

module fc_requant
  import fc_pkg::*;
(
  input  acc_t  acc0,
  input  acc_t  acc1,
  input  acc_t  acc2,
  input  acc_t  acc3,
  input  word_t bias,
  output word_t result
);

  acc_t acc_a   [BYTES_PER_WORD];
  acc_t sum     [BYTES_PER_WORD];
  acc_t shifted [BYTES_PER_WORD];

  assign acc_a[0] = acc0;
  assign acc_a[1] = acc1;
  assign acc_a[2] = acc2;
  assign acc_a[3] = acc3;

  always_comb begin
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      // Bias byte sign-extended to accumulator width
      sum[i]     = acc_a[i] + acc_t'(elem_t'(bias[8*i +: 8]));
      shifted[i] = sum[i] >>> OUT_SHIFT;
      if (sum[i] < 0) begin
        result[8*i +: 8] = 8'd0;
      end else if (shifted[i] > 127) begin
        result[8*i +: 8] = 8'd127;
      end else begin
        result[8*i +: 8] = shifted[i][7:0];
      end
    end
  end

endmodule

/* design/fc_top.sv */
// FC layer accelerator top level with AXI4-Stream input and output
// Ties buffers, controller, the four-PE chain and the requantizer together

`timescale 1ns/10ps

module fc_top
  import fc_pkg::*;
  import fc_ctrl_pkg::*;
#(
  parameter int FEAT_DEPTH = 64,
  parameter int BIAS_DEPTH = 16
) (
  input  logic              clk,
  input  logic              rstn,
  input  word_t             s_axis_tdata,
  input  logic              s_axis_tvalid,
  output logic              s_axis_tready,
  output word_t             m_axis_tdata,
  output logic              m_axis_tvalid,
  input  logic              m_axis_tready,
  output logic              m_axis_tlast,
  input  fc_cmd_e           cmd,
  input  logic              start,
  input  logic [SIZE_W-1:0] size,
  output logic              feat_loaded,
  output logic              bias_loaded,
  output logic              done
);

  localparam int FA_W = $clog2(FEAT_DEPTH);
  localparam int BA_W = $clog2(BIAS_DEPTH);

  logic                      feat_en;
  logic                      feat_we;
  logic [FA_W-1:0]           feat_addr;
  logic                      bias_en;
  logic                      bias_we;
  logic [BA_W-1:0]           bias_addr;
  logic [BYTES_PER_WORD-1:0] w_en;
  logic [BYTES_PER_WORD-1:0] w_we;
  logic [FA_W-1:0]           w_addr;
  word_t                     feat_dout;
  word_t                     bias_dout;
  word_t                     w_dout [BYTES_PER_WORD];
  word_t                     requant_bias;
  word_t                     requant_result;
  logic                      pe_en;
  logic [BYTES_PER_WORD-1:0] pe_first;
  elem_t                     pe_a;
  elem_t                     pe_b [BYTES_PER_WORD];
  elem_t                     a_chain [3];
  acc_t                      acc [BYTES_PER_WORD];

  fc_ctrl #(
    .FEAT_DEPTH (FEAT_DEPTH),
    .BIAS_DEPTH (BIAS_DEPTH)
  ) u_ctrl (
    .clk            (clk),
    .rstn           (rstn),
    .cmd            (cmd),
    .start          (start),
    .size           (size),
    .s_axis_tvalid  (s_axis_tvalid),
    .s_axis_tready  (s_axis_tready),
    .m_axis_tready  (m_axis_tready),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tlast   (m_axis_tlast),
    .m_axis_tdata   (m_axis_tdata),
    .feat_en        (feat_en),
    .feat_we        (feat_we),
    .feat_addr      (feat_addr),
    .bias_en        (bias_en),
    .bias_we        (bias_we),
    .bias_addr      (bias_addr),
    .w_en           (w_en),
    .w_we           (w_we),
    .w_addr         (w_addr),
    .feat_dout      (feat_dout),
    .bias_dout      (bias_dout),
    .w_dout0        (w_dout[0]),
    .w_dout1        (w_dout[1]),
    .w_dout2        (w_dout[2]),
    .w_dout3        (w_dout[3]),
    .pe_a           (pe_a),
    .pe_b0          (pe_b[0]),
    .pe_b1          (pe_b[1]),
    .pe_b2          (pe_b[2]),
    .pe_b3          (pe_b[3]),
    .pe_en          (pe_en),
    .pe_first0      (pe_first[0]),
    .pe_first1      (pe_first[1]),
    .pe_first2      (pe_first[2]),
    .pe_first3      (pe_first[3]),
    .requant_bias   (requant_bias),
    .requant_result (requant_result),
    .feat_loaded    (feat_loaded),
    .bias_loaded    (bias_loaded),
    .done           (done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Buffers, written straight from the input stream
  ////////////////////////////////////////////////////////////////////////////

  fc_buffer #(.DEPTH(FEAT_DEPTH)) u_feat_buf (
    .clk(clk), .en(feat_en), .we(feat_we), .addr(feat_addr),
    .din(s_axis_tdata), .dout(feat_dout)
  );

  fc_buffer #(.DEPTH(BIAS_DEPTH)) u_bias_buf (
    .clk(clk), .en(bias_en), .we(bias_we), .addr(bias_addr),
    .din(s_axis_tdata), .dout(bias_dout)
  );

  // Weight buffer i holds row 4g+i of the current group
  for (genvar i = 0; i < BYTES_PER_WORD; i++) begin : g_wbuf
    fc_buffer #(.DEPTH(FEAT_DEPTH)) u_w_buf (
      .clk(clk), .en(w_en[i]), .we(w_we[i]), .addr(w_addr),
      .din(s_axis_tdata), .dout(w_dout[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // PE chain and requantizer
  ////////////////////////////////////////////////////////////////////////////

  pe_mac u_pe0 (
    .clk(clk), .en(pe_en), .first(pe_first[0]), .a_in(pe_a),
    .b(pe_b[0]), .a_out(a_chain[0]), .acc(acc[0])
  );

  pe_mac u_pe1 (
    .clk(clk), .en(pe_en), .first(pe_first[1]), .a_in(a_chain[0]),
    .b(pe_b[1]), .a_out(a_chain[1]), .acc(acc[1])
  );

  pe_mac u_pe2 (
    .clk(clk), .en(pe_en), .first(pe_first[2]), .a_in(a_chain[1]),
    .b(pe_b[2]), .a_out(a_chain[2]), .acc(acc[2])
  );

  // End of the chain, the feature goes no further
  pe_mac u_pe3 (
    .clk(clk), .en(pe_en), .first(pe_first[3]), .a_in(a_chain[2]),
    .b(pe_b[3]), .a_out(), .acc(acc[3])
  );

  fc_requant u_requant (
    .acc0   (acc[0]),
    .acc1   (acc[1]),
    .acc2   (acc[2]),
    .acc3   (acc[3]),
    .bias   (requant_bias),
    .result (requant_result)
  );

endmodule

/* dv/fc_tb_assert.sv */
// Stream protocol assertions for the FC layer top level
// Output hold under back-pressure, ready after reset and the done pulse

`timescale 1ns/10ps

module fc_tb_assert
  import fc_pkg::*;
(
  input logic  clk,
  input logic  rstn,
  input word_t m_axis_tdata,
  input logic  m_axis_tvalid,
  input logic  m_axis_tready,
  input logic  m_axis_tlast,
  input logic  s_axis_tready,
  input logic  done
);

  // A waiting output word keeps its data and last flag
  a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
    (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
    else $error("output word changed while waiting for tready");

  a_ready_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !s_axis_tready)
    else $error("s_axis_tready high right after reset");

  a_done_after_last: assert property (@(posedge clk) disable iff (!rstn)
    done |-> $past(m_axis_tvalid && m_axis_tready && m_axis_tlast))
    else $error("done without a preceding tlast transfer");

  a_last_gives_done: assert property (@(posedge clk) disable iff (!rstn)
    (m_axis_tvalid && m_axis_tready && m_axis_tlast) |=> done)
    else $error("tlast transfer not followed by done");

endmodule

bind fc_top fc_tb_assert u_assert (
  .clk           (clk),
  .rstn          (rstn),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tlast  (m_axis_tlast),
  .s_axis_tready (s_axis_tready),
  .done          (done)
);

/* dv/fc_tb.sv */
// Testbench for the FC layer accelerator
// Random layers checked against a behavioral model of the output rule

`timescale 1ns/10ps

module fc_tb
  import fc_pkg::*;
  import fc_ctrl_pkg::*;
();

  logic              clk;
  logic              rstn;
  word_t             s_axis_tdata;
  logic              s_axis_tvalid;
  logic              s_axis_tready;
  word_t             m_axis_tdata;
  logic              m_axis_tvalid;
  logic              m_axis_tready;
  logic              m_axis_tlast;
  fc_cmd_e           cmd;
  logic              start;
  logic [SIZE_W-1:0] size;
  logic              feat_loaded;
  logic              bias_loaded;
  logic              done;

  integer seed;
  int     n_checks    = 0;
  int     n_errors    = 0;
  int     test_errs   = 0;
  int     cycles      = 0;
  int     cycle_limit = 16;
  int     done_cnt    = 0;
  int     n;
  int     m;
  int     feat [256];
  int     bias [64];
  int     wt [64][256];
  word_t  in_q [$];
  word_t  last_word;

  fc_top #(
    .FEAT_DEPTH (64),
    .BIAS_DEPTH (16)
  ) UUT (
    .clk           (clk),
    .rstn          (rstn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .cmd           (cmd),
    .start         (start),
    .size          (size),
    .feat_loaded   (feat_loaded),
    .bias_loaded   (bias_loaded),
    .done          (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog on the cycle budget of the tests started so far
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (rstn && done) begin
      done_cnt <= done_cnt + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks = n_checks + 1;
    if (got !== exp) begin
      n_errors = n_errors + 1;
      $display("[FAIL] t=%0t %s got=0x%08h exp=0x%08h", $time, name, got, exp);
    end
  endtask

  function automatic word_t expected_word(input int g, input int nn);
    word_t w;
    int    s;
    int    q;
    w = '0;
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      s = bias[4*g+i];
      for (int j = 0; j < nn; j++) begin
        s = s + feat[j] * wt[4*g+i][j];
      end
      q = s >>> OUT_SHIFT;
      if (s < 0) begin
        w[8*i +: 8] = 8'd0;
      end else if (q > 127) begin
        w[8*i +: 8] = 8'd127;
      end else begin
        w[8*i +: 8] = q[7:0];
      end
    end
    return w;
  endfunction

  task automatic add_budget(input int nn, input int mm, input bit loads);
    int beats;
    beats = mm * nn / 4 + mm / 4;
    if (loads) begin
      beats = beats + nn / 4 + mm / 4;
    end
    cycle_limit = cycle_limit + 4 * beats + nn * mm / 4 + 64;
  endtask

  task automatic end_test(input int num, input string name);
    $display("Test %0d %s: %0d errors", num, name, n_errors - test_errs);
    test_errs = n_errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_vectors(input int nn, input int mm);
    for (int j = 0; j < nn; j++) begin
      feat[j] = elem_t'($random(seed));
    end
    for (int r = 0; r < mm; r++) begin
      bias[r] = elem_t'($random(seed));
    end
  endtask

  task automatic fill_weights(input int nn, input int mm);
    for (int r = 0; r < mm; r++) begin
      for (int j = 0; j < nn; j++) begin
        wt[r][j] = elem_t'($random(seed));
      end
    end
  endtask

  task automatic start_cmd(input fc_cmd_e c, input int sz);
    @(posedge clk);
    cmd   <= c;
    size  <= SIZE_W'(sz);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // Sends the queued words, valid is held once raised until it transfers
  task automatic send_stream(input bit gaps);
    logic hold;
    hold = 1'b0;
    while (in_q.size() > 0) begin
      @(posedge clk);
      if (!hold && gaps && ({$random(seed)} % 4 == 0)) begin
        s_axis_tvalid <= 1'b0;
      end else begin
        s_axis_tvalid <= 1'b1;
        s_axis_tdata  <= in_q[0];
      end
      @(negedge clk);
      hold = s_axis_tvalid && !s_axis_tready;
      if (s_axis_tvalid && s_axis_tready) begin
        void'(in_q.pop_front());
      end
    end
    @(posedge clk);
    s_axis_tvalid <= 1'b0;
  endtask

  task automatic load_vector(input fc_cmd_e c, input int cnt, input bit gaps);
    word_t w;
    for (int k = 0; k < cnt / 4; k++) begin
      for (int b = 0; b < 4; b++) begin
        w[8*b +: 8] = (c == CMD_LOAD_FEAT) ? feat[4*k+b][7:0] : bias[4*k+b][7:0];
      end
      in_q.push_back(w);
    end
    start_cmd(c, cnt);
    send_stream(gaps);
  endtask

  task automatic recv_words(input int nn, input int mm, input bit bp);
    int got;
    got = 0;
    while (got < mm / 4) begin
      @(posedge clk);
      m_axis_tready <= bp ? ({$random(seed)} % 2 == 0) : 1'b1;
      @(negedge clk);
      if (m_axis_tvalid) begin
        check("s_axis_tready", s_axis_tready, 0);
      end
      if (m_axis_tvalid && m_axis_tready) begin
        last_word = m_axis_tdata;
        check("m_axis_tdata", m_axis_tdata, expected_word(got, nn));
        check("m_axis_tlast", m_axis_tlast, (got == mm / 4 - 1));
        got = got + 1;
      end
    end
    @(posedge clk);
    m_axis_tready <= 1'b0;
  endtask

  task automatic run_layer(input int nn, input int mm, input bit gaps, input bit bp);
    word_t w;
    int    d0;
    // Row 4g+i of each group, one row after the other
    for (int g = 0; g < mm / 4; g++) begin
      for (int i = 0; i < 4; i++) begin
        for (int k = 0; k < nn / 4; k++) begin
          for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = wt[4*g+i][4*k+b][7:0];
          end
          in_q.push_back(w);
        end
      end
    end
    d0 = done_cnt;
    start_cmd(CMD_RUN, 0);
    fork
      send_stream(gaps);
      recv_words(nn, mm, bp);
    join
    repeat (2) @(negedge clk);
    @(posedge clk);
    check("done pulse count", done_cnt - d0, 1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed          = 17281;
    rstn          = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b0;
    cmd           = CMD_LOAD_FEAT;
    start         = 1'b0;
    size          = '0;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;

    @(negedge clk);
    check("s_axis_tready", s_axis_tready, 0);
    check("m_axis_tvalid", m_axis_tvalid, 0);
    check("m_axis_tlast", m_axis_tlast, 0);
    check("done", done, 0);
    check("feat_loaded", feat_loaded, 0);
    check("bias_loaded", bias_loaded, 0);
    n = 8;
    m = 4;
    add_budget(n, m, 1);
    fill_vectors(n, m);
    load_vector(CMD_LOAD_FEAT, n, 0);
    @(negedge clk);
    check("feat_loaded", feat_loaded, 1);
    load_vector(CMD_LOAD_BIAS, m, 0);
    @(negedge clk);
    check("bias_loaded", bias_loaded, 1);
    end_test(1, "reset state");

    fill_weights(n, m);
    run_layer(n, m, 0, 0);
    end_test(2, "small layer");

    n = 4 * (1 + {$random(seed)} % 16);
    m = 4 * (1 + {$random(seed)} % 4);
    add_budget(n, m, 1);
    fill_vectors(n, m);
    fill_weights(n, m);
    load_vector(CMD_LOAD_FEAT, n, 1);
    load_vector(CMD_LOAD_BIAS, m, 1);
    run_layer(n, m, 1, 0);
    end_test(3, "multi-group layer");

    // Neurons 0 and 1 saturate high, neurons 2 and 3 go negative
    n = 8;
    m = 4;
    add_budget(n, m, 1);
    fill_vectors(n, m);
    for (int j = 0; j < n; j++) begin
      feat[j]  = 127;
      wt[0][j] = 127;
      wt[1][j] = 127;
      wt[2][j] = -128;
      wt[3][j] = -128;
    end
    load_vector(CMD_LOAD_FEAT, n, 0);
    load_vector(CMD_LOAD_BIAS, m, 0);
    run_layer(n, m, 0, 0);
    check("m_axis_tdata", last_word, 32'h0000_7f7f);
    end_test(4, "relu and saturation");

    n = 4 * (1 + {$random(seed)} % 16);
    m = 4 * (1 + {$random(seed)} % 4);
    add_budget(n, m, 1);
    fill_vectors(n, m);
    fill_weights(n, m);
    load_vector(CMD_LOAD_FEAT, n, 1);
    load_vector(CMD_LOAD_BIAS, m, 1);
    run_layer(n, m, 1, 1);
    end_test(5, "output back-pressure");

    add_budget(n, m, 0);
    fill_weights(n, m);
    run_layer(n, m, 1, 0);
    end_test(6, "second run");

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
common/fc_pkg.sv
common/fc_ctrl_pkg.sv
pe/pe_mult.sv
pe/pe_mac.sv
design/fc_buffer.sv
design/fc_ctrl.sv
design/fc_requant.sv
design/fc_top.sv
dv/fc_tb_assert.sv
dv/fc_tb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the FC layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fc_tb -f all.f -o fc_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fc_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
